/* source/isa_pkg.sv */
/*
 * Instruction set constants for the fetch stage
 * Field layout, opcode values, vectors and predictor sizing
 */
`default_nettype none

package isa_pkg;

   // Word and address widths
   localparam int XLEN = 32;
   localparam int AW   = 10;
   // Word PC drops the two byte offset bits
   localparam int PCW  = AW - 2;
   localparam int IMEM_WORDS = 1 << PCW;

   // Opcode field, bits 5 to 0
   localparam int OPC_LSB = 0;
   localparam int OPC_W   = 6;

   localparam logic [OPC_W-1:0] OPC_JMP     = 6'h01;
   localparam logic [OPC_W-1:0] OPC_JAL     = 6'h02;
   localparam logic [OPC_W-1:0] OPC_BT      = 6'h03;
   localparam logic [OPC_W-1:0] OPC_BF      = 6'h04;
   localparam logic [OPC_W-1:0] OPC_SYSCALL = 6'h05;
   localparam logic [OPC_W-1:0] OPC_RET     = 6'h06;

   // Signed word offset, bits 31 to 6
   localparam int OFFS_W = 26;

   // Word vector addresses
   localparam logic [PCW-1:0] VEC_SYSCALL = 8'h04;
   localparam logic [PCW-1:0] VEC_IRQ     = 8'h08;
   localparam logic [PCW-1:0] VEC_FAULT   = 8'h0C;

   // Predictor table, indexed by low PC bits
   localparam int BP_IDX_W   = 4;
   localparam int BP_ENTRIES = 1 << BP_IDX_W;
   localparam logic [1:0] BP_INIT = 2'b01;

   // Idle cycles between reset release and the first command
   localparam int STARTUP_CYCLES = 2;
   localparam int STARTUP_W      = $clog2(STARTUP_CYCLES + 1);

endpackage

`default_nettype wire

/* source/fetch_if_pkg.sv */
/*
 * Bundles exchanged between fetch, memory, predictor and decode
 */
`default_nettype none

package fetch_if_pkg;

   // Read command to instruction memory
   typedef struct packed {
      logic [isa_pkg::PCW-1:0]  addr;
   } imem_cmd_t;

   // Read response, tagged with its word address
   typedef struct packed {
      logic [isa_pkg::XLEN-1:0] insn;
      logic [isa_pkg::PCW-1:0]  tag;
   } imem_rsp_t;

   // Predecode result, flags mutually exclusive
   typedef struct packed {
      logic                     is_jmp;
      logic                     is_bcc;
      logic                     bcc_true;
      logic                     link;
      logic                     is_syscall;
      logic                     is_ret;
      // Sign extended word offset
      logic [isa_pkg::XLEN-1:0] offset;
   } predec_t;

   typedef struct packed {
      logic [isa_pkg::PCW-1:0]  pc;
   } bp_query_t;

   // Resolution from a later stage
   typedef struct packed {
      logic [isa_pkg::PCW-1:0]  pc;
      logic                     taken;
   } bp_update_t;

   // Slot content handed to decode
   typedef struct packed {
      logic [isa_pkg::XLEN-1:0] insn;
      logic [isa_pkg::PCW-1:0]  pc;
      predec_t                  pd;
      logic                     predicted_taken;
      logic [isa_pkg::PCW-1:0]  alt_tgt;
      logic                     exception;
      logic                     exc_irq;
      logic                     exc_fault;
   } decode_bundle_t;

   typedef struct packed {
      logic [isa_pkg::PCW-1:0]  tgt;
   } redirect_t;

endpackage

`default_nettype wire

/* source/insn_predecoder.sv */
/*
 * Instruction predecoder
 * Classifies one word into branch kind, offset and link flag
 */
`timescale 1ns/10ps
`default_nettype none

module insn_predecoder (
   input  logic [isa_pkg::XLEN-1:0] insn,
   output fetch_if_pkg::predec_t    predec
);

   logic [isa_pkg::OPC_W-1:0]  opc;
   logic [isa_pkg::XLEN-1:0]   offs_sext;

   // Opcode in the low bits
   assign opc = insn[isa_pkg::OPC_LSB +: isa_pkg::OPC_W];

   // Offset occupies everything above the opcode
   assign offs_sext = {{(isa_pkg::XLEN - isa_pkg::OFFS_W){insn[isa_pkg::XLEN-1]}},
                       insn[isa_pkg::XLEN-1 -: isa_pkg::OFFS_W]};

   always_comb begin
      predec = '0;
      case (opc)
         isa_pkg::OPC_JMP: begin
            predec.is_jmp = 1'b1;
            predec.offset = offs_sext;
         end
         // Same as jmp plus link
         isa_pkg::OPC_JAL: begin
            predec.is_jmp = 1'b1;
            predec.link   = 1'b1;
            predec.offset = offs_sext;
         end
         isa_pkg::OPC_BT: begin
            predec.is_bcc   = 1'b1;
            predec.bcc_true = 1'b1;
            predec.offset   = offs_sext;
         end
         // bf differs from bt only in bcc_true
         isa_pkg::OPC_BF: begin
            predec.is_bcc = 1'b1;
            predec.offset = offs_sext;
         end
         isa_pkg::OPC_SYSCALL: begin
            predec.is_syscall = 1'b1;
         end
         isa_pkg::OPC_RET: begin
            predec.is_ret = 1'b1;
         end
         // Ordinary instruction, no flags
         default: begin
            predec = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
/*
 * Conditional branch predictor
 * Two-bit saturating counters, read by PC and trained by resolution
 */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
   input  logic                    clk,
   input  logic                    rst_n,
   input  fetch_if_pkg::bp_query_t query,
   output logic                    pred_taken,
   input  logic                    upd_valid,
   input  fetch_if_pkg::bp_update_t upd
);

   logic [1:0]                   ctr [isa_pkg::BP_ENTRIES];
   logic [isa_pkg::BP_IDX_W-1:0] rd_idx;
   logic [isa_pkg::BP_IDX_W-1:0] wr_idx;
   logic [1:0]                   wr_ctr;

   // Low PC bits pick the entry
   assign rd_idx = query.pc[isa_pkg::BP_IDX_W-1:0];
   assign wr_idx = upd.pc[isa_pkg::BP_IDX_W-1:0];
   assign wr_ctr = ctr[wr_idx];

   // Counter MSB is the prediction
   assign pred_taken = ctr[rd_idx][1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Every entry starts weakly not taken
         for (int i = 0; i < isa_pkg::BP_ENTRIES; i++) begin
            ctr[i] <= isa_pkg::BP_INIT;
         end
      end else if (upd_valid) begin
         // Saturate at both ends
         if (upd.taken) begin
            if (wr_ctr != 2'b11) begin
               ctr[wr_idx] <= wr_ctr + 2'd1;
            end
         end else begin
            if (wr_ctr != 2'b00) begin
               ctr[wr_idx] <= wr_ctr - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* source/insn_sram.sv */
/*
 * Instruction memory, 256 words
 * Load port for program download, one-cycle tagged read
 */
`timescale 1ns/10ps
`default_nettype none

module insn_sram (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      load_valid,
   input  logic [isa_pkg::PCW-1:0]   load_addr,
   input  logic [isa_pkg::XLEN-1:0]  load_data,
   input  logic                      cmd_valid,
   output logic                      cmd_ready,
   input  fetch_if_pkg::imem_cmd_t   cmd,
   output logic                      rsp_valid,
   output fetch_if_pkg::imem_rsp_t   rsp
);

   logic [isa_pkg::XLEN-1:0] mem [isa_pkg::IMEM_WORDS];
   logic                     cmd_fire;

   // Single cycle read, never stalls
   assign cmd_ready = 1'b1;
   assign cmd_fire  = cmd_valid & cmd_ready;

   // Program download, used while fetch is idle
   always_ff @(posedge clk) begin
      if (load_valid) begin
         mem[load_addr] <= load_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= cmd_fire;
      end
   end

   // Word and its address come back together
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         rsp.insn <= mem[cmd.addr];
         rsp.tag  <= cmd.addr;
      end
   end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
/*
 * Fetch unit: PC, redirect priority, exception vectoring
 * and a one-slot output buffer toward decode
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
   input  logic                           clk,
   input  logic                           rst_n,
   output logic                           cmd_valid,
   input  logic                           cmd_ready,
   output fetch_if_pkg::imem_cmd_t        cmd,
   input  logic                           rsp_valid,
   input  fetch_if_pkg::imem_rsp_t        rsp,
   output fetch_if_pkg::bp_query_t        bp_query,
   input  logic                           bp_taken,
   input  logic                           flush_valid,
   input  fetch_if_pkg::redirect_t        flush,
   input  logic                           irq,
   input  logic                           fetch_fault,
   input  logic [isa_pkg::PCW-1:0]        epc,
   output logic                           dec_valid,
   input  logic                           dec_ready,
   output fetch_if_pkg::decode_bundle_t   dec
);

   logic [isa_pkg::STARTUP_W-1:0] start_cnt;
   logic                          started;
   logic                          busy;
   logic [isa_pkg::PCW-1:0]       pc;
   logic [isa_pkg::PCW-1:0]       last_addr;
   logic                          cmd_fire;
   logic                          slot_free;
   logic                          rsp_hit;
   logic                          slot_load;
   logic                          exc;
   logic                          exc_irq;
   logic                          exc_fault;
   logic [isa_pkg::XLEN-1:0]      insn_eff;
   fetch_if_pkg::predec_t         pd;
   logic [isa_pkg::PCW-1:0]       seq_pc;
   logic [isa_pkg::PCW-1:0]       br_tgt;
   logic [isa_pkg::PCW-1:0]       next_pc;
   logic                          bcc_taken;
   fetch_if_pkg::decode_bundle_t  bundle;

   // Startup delay after reset
   assign started = (start_cnt == isa_pkg::STARTUP_CYCLES);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start_cnt <= '0;
      end else if (!started) begin
         start_cnt <= start_cnt + 1'b1;
      end
   end

   // Slot can take data next cycle
   assign slot_free = ~dec_valid | dec_ready;

   // One command in flight, issued only if its response will fit
   assign cmd_valid = started & ~busy & slot_free;
   assign cmd.addr  = pc;
   assign cmd_fire  = cmd_valid & cmd_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
      end else if (cmd_fire) begin
         busy <= 1'b1;
      end else if (rsp_valid) begin
         busy <= 1'b0;
      end
   end

   // Address last commanded; a flush retargets it so stale tags miss
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_addr <= '0;
      end else if (flush_valid) begin
         last_addr <= flush.tgt;
      end else if (cmd_fire) begin
         last_addr <= pc;
      end
   end

   assign rsp_hit   = rsp_valid & (rsp.tag == last_addr) & ~flush_valid;
   // Bypass load, slot empty or drained this cycle
   assign slot_load = rsp_hit & slot_free;

   // IRQ wins over fault
   assign exc_irq   = irq;
   assign exc_fault = fetch_fault & ~irq;
   assign exc       = irq | fetch_fault;

   // Exception entry carries a zero word
   assign insn_eff = exc ? '0 : rsp.insn;

   insn_predecoder u_predec (
      .insn   (insn_eff),
      .predec (pd)
   );

   // Predictor looks up the responding PC
   assign bp_query.pc = rsp.tag;

   assign seq_pc    = rsp.tag + 1'b1;
   assign br_tgt    = rsp.tag + pd.offset[isa_pkg::PCW-1:0];
   assign bcc_taken = pd.is_bcc & bp_taken;

   // Next PC priority chain
   always_comb begin
      if (flush_valid) begin
         next_pc = flush.tgt;
      end else if (exc_irq) begin
         next_pc = isa_pkg::VEC_IRQ;
      end else if (exc_fault) begin
         next_pc = isa_pkg::VEC_FAULT;
      end else if (pd.is_syscall) begin
         next_pc = isa_pkg::VEC_SYSCALL;
      end else if (pd.is_ret) begin
         next_pc = epc;
      end else if (pd.is_jmp || bcc_taken) begin
         next_pc = br_tgt;
      end else begin
         next_pc = seq_pc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (flush_valid || slot_load) begin
         pc <= next_pc;
      end
   end

   // Bundle for decode
   always_comb begin
      bundle.insn            = insn_eff;
      bundle.pc              = rsp.tag;
      bundle.pd              = pd;
      bundle.predicted_taken = bcc_taken;
      // Other path of a branch
      bundle.alt_tgt         = pd.is_bcc ? (bp_taken ? seq_pc : br_tgt) : '0;
      bundle.exception       = exc;
      bundle.exc_irq         = exc_irq;
      bundle.exc_fault       = exc_fault;
   end

   // Output slot valid, flush empties it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_valid <= 1'b0;
      end else if (flush_valid) begin
         dec_valid <= 1'b0;
      end else if (slot_load) begin
         dec_valid <= 1'b1;
      end else if (dec_ready) begin
         dec_valid <= 1'b0;
      end
   end

   // Held while decode stalls
   always_ff @(posedge clk) begin
      if (slot_load) begin
         dec <= bundle;
      end
   end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
/*
 * Fetch stage top: fetch unit, branch predictor and instruction memory
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load_valid,
   input  logic [isa_pkg::PCW-1:0]       load_addr,
   input  logic [isa_pkg::XLEN-1:0]      load_data,
   input  logic                          flush_valid,
   input  fetch_if_pkg::redirect_t       flush,
   input  logic                          irq,
   input  logic                          fetch_fault,
   input  logic [isa_pkg::PCW-1:0]       epc,
   input  logic                          upd_valid,
   input  fetch_if_pkg::bp_update_t      upd,
   output logic                          dec_valid,
   input  logic                          dec_ready,
   output fetch_if_pkg::decode_bundle_t  dec
);

   // Memory side
   logic                     cmd_valid;
   logic                     cmd_ready;
   fetch_if_pkg::imem_cmd_t  cmd;
   logic                     rsp_valid;
   fetch_if_pkg::imem_rsp_t  rsp;
   // Predictor side
   fetch_if_pkg::bp_query_t  bp_query;
   logic                     bp_taken;

   fetch_unit u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd         (cmd),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp),
      .bp_query    (bp_query),
      .bp_taken    (bp_taken),
      .flush_valid (flush_valid),
      .flush       (flush),
      .irq         (irq),
      .fetch_fault (fetch_fault),
      .epc         (epc),
      .dec_valid   (dec_valid),
      .dec_ready   (dec_ready),
      .dec         (dec)
   );

   branch_predictor u_bp (
      .clk        (clk),
      .rst_n      (rst_n),
      .query      (bp_query),
      .pred_taken (bp_taken),
      .upd_valid  (upd_valid),
      .upd        (upd)
   );

   insn_sram u_imem (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

`default_nettype wire

/* tb/fetch_asserts.sv */
/*
 * Fetch unit checks: predecode exclusivity, reset state, slot stability
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_asserts (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         cmd_valid,
   input logic                         dec_valid,
   input logic                         dec_ready,
   input logic                         flush_valid,
   input fetch_if_pkg::decode_bundle_t dec,
   input fetch_if_pkg::predec_t        pd
);

   // At most one instruction class at a time
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({pd.is_jmp, pd.is_bcc, pd.is_syscall, pd.is_ret}))
      else $error("predecode flags not mutually exclusive");

   // Nothing issued or offered right after reset
   assert property (@(posedge clk) !rst_n |=> !cmd_valid && !dec_valid)
      else $error("cmd_valid or dec_valid high after reset");

   // Stalled slot holds its content unless flushed
   assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid && !dec_ready && !flush_valid |=> dec_valid && $stable(dec))
      else $error("decode slot changed while stalled");

endmodule

bind fetch_unit fetch_asserts u_asserts (
   .clk         (clk),
   .rst_n       (rst_n),
   .cmd_valid   (cmd_valid),
   .dec_valid   (dec_valid),
   .dec_ready   (dec_ready),
   .flush_valid (flush_valid),
   .dec         (dec),
   .pd          (pd)
);

`default_nettype wire

/* tb/tb_fetch.sv */
/*
 * Fetch stage testbench
 * Table of scenarios checked against a reference fetch model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch;

   localparam int NROWS = 9;
   localparam int PCW   = isa_pkg::PCW;

   // Scenario row, its program words held apart in prog
   typedef struct packed {
      logic [7:0]     irq_m;
      logic [7:0]     fault_m;
      logic [7:0]     flush_at;
      logic [PCW-1:0] flush_tgt;
      logic           bp;
      logic [7:0]     n_obs;
      logic [PCW-1:0] train_pc;
      logic [1:0]     train_cnt;
      logic [PCW-1:0] epc;
   } row_t;

   logic                         clk;
   logic                         rst_n;
   logic                         load_valid;
   logic [PCW-1:0]               load_addr;
   logic [isa_pkg::XLEN-1:0]     load_data;
   logic                         flush_valid;
   fetch_if_pkg::redirect_t      flush;
   logic                         irq;
   logic                         fetch_fault;
   logic [PCW-1:0]               epc;
   logic                         upd_valid;
   fetch_if_pkg::bp_update_t     upd;
   logic                         dec_valid;
   logic                         dec_ready;
   fetch_if_pkg::decode_bundle_t dec;

   row_t        rows [NROWS];
   logic [31:0] prog [NROWS][8];
   // Model memory image and counter table
   logic [31:0] img [256];
   logic [1:0]  tab [16];
   integer      seed;

   fetch_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_valid  (load_valid),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .flush_valid (flush_valid),
      .flush       (flush),
      .irq         (irq),
      .fetch_fault (fetch_fault),
      .epc         (epc),
      .upd_valid   (upd_valid),
      .upd         (upd),
      .dec_valid   (dec_valid),
      .dec_ready   (dec_ready),
      .dec         (dec)
   );

   always #5 clk = ~clk;

   // Offset above the opcode
   function automatic logic [31:0] enc(input logic [5:0] opc, input int offs);
      return {offs[25:0], opc};
   endfunction

   // Ordinary instruction with opcode 0x20
   function automatic logic [31:0] ord_word(input int i);
      return {16'hA5C3, i[7:0], 2'b00, 6'h20};
   endfunction

   // Background content, distinct for every address
   function automatic logic [31:0] fill_word(input logic [7:0] a);
      return {a, ~a, a, a[1:0], 6'h20};
   endfunction

   function automatic row_t mk_row(input logic [7:0] irq_m, input logic [7:0] fault_m,
                                   input logic [7:0] flush_at, input logic [7:0] flush_tgt,
                                   input logic bp, input logic [7:0] n_obs,
                                   input logic [7:0] train_pc, input logic [1:0] train_cnt,
                                   input logic [7:0] epc_v);
      row_t r;
      r = '{irq_m, fault_m, flush_at, flush_tgt, bp, n_obs, train_pc, train_cnt, epc_v};
      return r;
   endfunction

   // Mask bit for one response or entry
   function automatic logic bit_at(input logic [7:0] m, input int idx);
      return (idx < 8) ? m[idx] : 1'b0;
   endfunction

   // Reference fetch rule for one delivered entry
   function automatic void predict(input logic [PCW-1:0] pc, input logic ei, input logic ef,
                                   input logic [PCW-1:0] epc_v,
                                   output fetch_if_pkg::decode_bundle_t e,
                                   output logic [PCW-1:0] npc);
      logic [31:0]    w;
      logic [5:0]     opc;
      logic [31:0]    off;
      logic [PCW-1:0] tgt;
      logic           tk;
      e = '0;
      e.pc = pc;
      if (ei || ef) begin
         // Exception entry carries a zero word
         // Irq beats fault
         e.exception = 1'b1;
         e.exc_irq   = ei;
         e.exc_fault = ef && !ei;
         npc = ei ? isa_pkg::VEC_IRQ : isa_pkg::VEC_FAULT;
         return;
      end
      w   = img[pc];
      opc = w[5:0];
      // Sign extended word offset from bits 31 to 6
      off = {{6{w[31]}}, w[31:6]};
      tgt = pc + off[PCW-1:0];
      // Counter MSB gives the prediction
      tk  = tab[pc[3:0]][1];
      e.insn = w;
      npc = pc + 8'd1;
      case (opc)
         isa_pkg::OPC_JMP, isa_pkg::OPC_JAL: begin
            e.pd.is_jmp = 1'b1;
            e.pd.link   = (opc == isa_pkg::OPC_JAL);
            e.pd.offset = off;
            npc = tgt;
         end
         isa_pkg::OPC_BT, isa_pkg::OPC_BF: begin
            e.pd.is_bcc   = 1'b1;
            e.pd.bcc_true = (opc == isa_pkg::OPC_BT);
            e.pd.offset   = off;
            e.predicted_taken = tk;
            // Other path of the branch
            e.alt_tgt = tk ? pc + 8'd1 : tgt;
            if (tk) begin
               npc = tgt;
            end
         end
         isa_pkg::OPC_SYSCALL: begin
            e.pd.is_syscall = 1'b1;
            npc = isa_pkg::VEC_SYSCALL;
         end
         isa_pkg::OPC_RET: begin
            e.pd.is_ret = 1'b1;
            npc = epc_v;
         end
         default: ;
      endcase
   endfunction

   task automatic check_bundle(input fetch_if_pkg::decode_bundle_t got,
                               input fetch_if_pkg::decode_bundle_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s bundle got %h expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic check_pc(input logic [PCW-1:0] got, input logic [PCW-1:0] exp,
                           input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s pc got %h expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // One word through the load port, mirrored in the model image
   task automatic load_word(input logic [7:0] a, input logic [31:0] d);
      @(negedge clk);
      load_valid = 1'b1;
      load_addr  = a;
      load_data  = d;
      img[a]     = d;
   endtask

   // Watchdog allows 200 cycles per scenario
   initial begin
      repeat (NROWS * 200) @(posedge clk);
      $display("Timeout: the decode stream did not complete in time");
      $display("Test failed");
      $fatal(1);
   end

   initial begin
      int                           r;
      int                           cyc;
      int                           nd;
      int                           nr;
      logic [PCW-1:0]               mpc;
      logic [PCW-1:0]               npc;
      logic                         flushed;
      fetch_if_pkg::decode_bundle_t e;
      clk = 1'b0;
      rst_n = 1'b0;
      load_valid = 1'b0;
      load_addr = '0;
      load_data = '0;
      flush_valid = 1'b0;
      flush = '0;
      irq = 1'b0;
      fetch_fault = 1'b0;
      epc = '0;
      upd_valid = 1'b0;
      upd = '0;
      dec_ready = 1'b1;
      seed = 32'h90d5bce7;
      for (int k = 0; k < NROWS; k++) begin
         for (int i = 0; i < 8; i++) begin
            prog[k][i] = ord_word(i);
         end
      end
      // Straight line, then jumps, syscall and ret
      rows[0] = mk_row(8'h00, 8'h00, 8'hFF, 8'h00, 1'b0, 8'd10, 8'h00, 2'd0, 8'h00);
      rows[1] = mk_row(8'h00, 8'h00, 8'hFF, 8'h00, 1'b0, 8'd6, 8'h00, 2'd0, 8'h40);
      prog[1][0] = enc(isa_pkg::OPC_JMP, 2);
      prog[1][2] = enc(isa_pkg::OPC_JAL, 1);
      prog[1][3] = enc(isa_pkg::OPC_SYSCALL, 0);
      prog[1][4] = enc(isa_pkg::OPC_RET, 0);
      // Untrained branches fall through
      rows[2] = mk_row(8'h00, 8'h00, 8'hFF, 8'h00, 1'b0, 8'd4, 8'h00, 2'd0, 8'h00);
      prog[2][0] = enc(isa_pkg::OPC_BT, 5);
      prog[2][1] = enc(isa_pkg::OPC_BF, 5);
      // Trained bt at word 1 jumps to 7
      rows[3] = mk_row(8'h00, 8'h00, 8'hFF, 8'h00, 1'b0, 8'd4, 8'h01, 2'd2, 8'h00);
      prog[3][1] = enc(isa_pkg::OPC_BT, 6);
      // Interrupt, fault, both at once, then a flush
      rows[4] = mk_row(8'h02, 8'h00, 8'hFF, 8'h00, 1'b0, 8'd4, 8'h00, 2'd0, 8'h00);
      rows[5] = mk_row(8'h08, 8'h0C, 8'hFF, 8'h00, 1'b0, 8'd5, 8'h00, 2'd0, 8'h00);
      rows[6] = mk_row(8'h00, 8'h00, 8'd2, 8'h30, 1'b0, 8'd5, 8'h00, 2'd0, 8'h00);
      // Rows 1 and 3 again under random back-pressure
      rows[7] = rows[1];
      rows[7].bp = 1'b1;
      prog[7] = prog[1];
      rows[8] = rows[3];
      rows[8].bp = 1'b1;
      prog[8] = prog[3];
      // Trained bf at word 1 takes the same path
      prog[8][1] = enc(isa_pkg::OPC_BF, 6);

      // Whole memory gets background content first
      for (int a = 0; a < 256; a++) begin
         load_word(a[7:0], fill_word(a[7:0]));
      end
      for (int k = 0; k < NROWS; k++) begin
         // Program download under reset
         @(negedge clk);
         rst_n = 1'b0;
         for (int i = 0; i < 8; i++) begin
            load_word(i[7:0], prog[k][i]);
         end
         @(negedge clk);
         load_valid = 1'b0;
         repeat (4) @(negedge clk);
         rst_n = 1'b1;
         epc = rows[k].epc;
         for (int i = 0; i < 16; i++) begin
            tab[i] = isa_pkg::BP_INIT;
         end
         mpc = '0;
         nd = 0;
         nr = 0;
         cyc = 0;
         flushed = 1'b0;
         while (nd < int'(rows[k].n_obs)) begin
            @(negedge clk);
            // Resolve port training mirrored in the model table
            upd_valid = (cyc < int'(rows[k].train_cnt));
            upd.pc    = rows[k].train_pc;
            upd.taken = 1'b1;
            if (upd_valid && tab[upd.pc[3:0]] != 2'b11) begin
               tab[upd.pc[3:0]] += 2'd1;
            end
            // Exceptions ride on a specific response
            irq = 1'b0;
            fetch_fault = 1'b0;
            if (dut.rsp_valid) begin
               irq = bit_at(rows[k].irq_m, nr);
               fetch_fault = bit_at(rows[k].fault_m, nr);
               nr++;
            end
            flush_valid = 1'b0;
            if (!flushed && nd == int'(rows[k].flush_at)) begin
               // Model continues from the flush target
               flush_valid = 1'b1;
               flush.tgt = rows[k].flush_tgt;
               flushed = 1'b1;
               mpc = rows[k].flush_tgt;
               dec_ready = 1'b0;
            end else if (rows[k].bp) begin
               r = $random(seed);
               dec_ready = r[0];
            end else begin
               dec_ready = 1'b1;
            end
            // Handshake completes at the coming rising edge
            if (dec_valid && dec_ready) begin
               predict(mpc, bit_at(rows[k].irq_m, nd), bit_at(rows[k].fault_m, nd),
                       rows[k].epc, e, npc);
               check_pc(dec.pc, mpc, $sformatf("row %0d entry %0d", k, nd));
               check_bundle(dec, e, $sformatf("row %0d entry %0d", k, nd));
               mpc = npc;
               nd++;
            end
            cyc++;
         end
         @(negedge clk);
         irq = 1'b0;
         fetch_fault = 1'b0;
         flush_valid = 1'b0;
         upd_valid = 1'b0;
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
source/isa_pkg.sv
source/fetch_if_pkg.sv
source/insn_predecoder.sv
source/branch_predictor.sv
source/insn_sram.sv
source/fetch_unit.sv
source/fetch_top.sv
tb/fetch_asserts.sv
tb/tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_fetch \
   -o tb_fetch_sim > build.log 2>&1 \
   && ./obj_dir/tb_fetch_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log \
   && echo "PASS" \
   || { cat sim.log; echo "FAIL"; exit 1; }
